// File: vec_alu_pkg.sv
package vec_alu_pkg;

	// Operand and result width, lane layout is built around it
	localparam int VEC_W = 64;

	// Default Wishbone word address width
	localparam int WB_ADR_W = 2;

	typedef logic [VEC_W-1:0] vec_t;

	// Lane width select, lane 0 is always the most significant lane
	typedef enum logic [1:0] {
		LW_8  = 2'b00,
		LW_16 = 2'b01,
		LW_32 = 2'b10,
		LW_64 = 2'b11
	} lane_width_e;

	// ALU opcodes
	typedef enum logic [4:0] {
		OP_AND  = 5'd1,
		OP_OR   = 5'd2,
		OP_XOR  = 5'd3,
		OP_NOT  = 5'd4,
		OP_MOV  = 5'd5,
		OP_ADD  = 5'd6,
		OP_SUB  = 5'd7,
		OP_MULE = 5'd8,
		OP_MULO = 5'd9,
		OP_SLL  = 5'd10,
		OP_SRL  = 5'd11,
		OP_SRA  = 5'd12,
		OP_RTTH = 5'd13
	} vec_op_e;

	// Control word, opcode in the upper bits
	typedef struct packed {
		vec_op_e     opcode;
		lane_width_e width;
	} vec_ctrl_t;

	// Wishbone classic request from the host
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [WB_ADR_W-1:0] adr;
		vec_t                dat;
	} wb_req_t;

	// Wishbone classic response to the host
	typedef struct packed {
		logic ack;
		vec_t dat;
	} wb_rsp_t;

	// Word addresses
	localparam logic [WB_ADR_W-1:0] REG_OPA  = 2'd0;
	localparam logic [WB_ADR_W-1:0] REG_OPB  = 2'd1;
	// Write starts an operation, read returns the result
	localparam logic [WB_ADR_W-1:0] REG_CTRL = 2'd2;
	// Bit 0 holds the sticky error flag
	localparam logic [WB_ADR_W-1:0] REG_STAT = 2'd3;

endpackage

// File: wb_vec_regs.sv
`timescale 1ns/1ps

module wb_vec_regs import vec_alu_pkg::*; #(
	parameter int WB_ADR_W = vec_alu_pkg::WB_ADR_W
) (
	input  logic      clk,
	input  logic      arst_n,
	input  wb_req_t   wb_req,
	output wb_rsp_t   wb_rsp,
	output vec_t      opa,
	output vec_t      opb,
	output vec_ctrl_t ctrl,
	input  vec_t      result,
	input  logic      unsupported
);

	logic [WB_ADR_W-1:0] adr;
	logic                ack;
	logic                req_new;
	logic                wr_en;
	logic                rd_en;
	logic                ctrl_pend;
	logic                err;
	vec_t                opa_q;
	vec_t                opb_q;
	vec_ctrl_t           ctrl_q;
	vec_t                result_q;
	vec_t                rd_dat;

	assign adr = WB_ADR_W'(wb_req.adr);

	// First cycle the slave sees a strobe
	assign req_new = wb_req.cyc & wb_req.stb & ~ack;
	assign wr_en   = req_new & wb_req.we;
	assign rd_en   = req_new & ~wb_req.we;

	// Single-cycle ack, one clock after the strobe is first sampled
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack <= 1'b0;
		end else begin
			ack <= req_new;
		end
	end

	// Operand and control writes land on the first sampling edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			opa_q     <= '0;
			opb_q     <= '0;
			ctrl_q    <= vec_ctrl_t'('0);
			ctrl_pend <= 1'b0;
		end else begin
			// High exactly during the ack cycle of a control write
			ctrl_pend <= wr_en && (adr == WB_ADR_W'(REG_CTRL));
			if (wr_en) begin
				case (adr)
					WB_ADR_W'(REG_OPA):  opa_q  <= wb_req.dat;
					WB_ADR_W'(REG_OPB):  opb_q  <= wb_req.dat;
					WB_ADR_W'(REG_CTRL): ctrl_q <= vec_ctrl_t'(wb_req.dat[$bits(vec_ctrl_t)-1:0]);
					default: ;
				endcase
			end
		end
	end

	// Core output settles during the ack cycle
	// Result and error flag are captured at its closing edge
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			result_q <= '0;
			err      <= 1'b0;
		end else if (ctrl_pend) begin
			result_q <= result;
			err      <= unsupported;
		end
	end

	// Read data registered so it is valid while ack is high
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_dat <= '0;
		end else if (rd_en) begin
			case (adr)
				WB_ADR_W'(REG_OPA):  rd_dat <= opa_q;
				WB_ADR_W'(REG_OPB):  rd_dat <= opb_q;
				// Control address reads back the result
				WB_ADR_W'(REG_CTRL): rd_dat <= result_q;
				WB_ADR_W'(REG_STAT): rd_dat <= {{(VEC_W-1){1'b0}}, err};
				default:             rd_dat <= '0;
			endcase
		end
	end

	assign wb_rsp.ack = ack;
	assign wb_rsp.dat = rd_dat;

	assign opa  = opa_q;
	assign opb  = opb_q;
	assign ctrl = ctrl_q;

endmodule

// File: vec_lane_addsub.sv
`timescale 1ns/1ps

module vec_lane_addsub import vec_alu_pkg::*; (
	input  vec_t        a,
	input  vec_t        b,
	input  lane_width_e width,
	input  logic        sub,
	output vec_t        sum
);

	localparam int NBYTE = VEC_W / 8;

	vec_t             b_op;
	logic [NBYTE-1:1] lane_start;
	logic [NBYTE-1:1] carry;

	// Two's complement subtract as A plus inverted B plus one
	assign b_op = sub ? ~b : b;

	// Bytes above byte 0 that open a new lane
	// Byte 0 is the LSB byte and always opens one
	always_comb begin
		case (width)
			LW_8:    lane_start = 7'h7F;
			LW_16:   lane_start = 7'h2A;
			LW_32:   lane_start = 7'h08;
			default: lane_start = 7'h00;
		endcase
	end

	// Byte-wide adders chained across bytes of one lane
	for (genvar k = 0; k < NBYTE; k++) begin : g_byte
		logic [8:0] byte_sum;
		logic       cin;

		// Lane boundary takes the subtract bit instead of the ripple carry
		if (k == 0) begin : g_first
			assign cin = sub;
		end else begin : g_next
			assign cin = lane_start[k] ? sub : carry[k];
		end

		assign byte_sum = {1'b0, a[8*k +: 8]} + {1'b0, b_op[8*k +: 8]} + {8'd0, cin};
		assign sum[8*k +: 8] = byte_sum[7:0];

		// Top byte carry is dropped so every lane wraps
		if (k < NBYTE - 1) begin : g_carry
			assign carry[k+1] = byte_sum[8];
		end
	end

endmodule

// File: vec_lane_mul.sv
`timescale 1ns/1ps

module vec_lane_mul import vec_alu_pkg::*; (
	input  vec_t        a,
	input  vec_t        b,
	input  lane_width_e width,
	input  logic        odd,
	output vec_t        prod
);

	// One full result per supported lane width, 8 16 and 32 bits
	logic [2:0][VEC_W-1:0] prod_w;

	for (genvar g = 0; g < 3; g++) begin : g_width
		localparam int LW = 8 << g;

		// Each slot is two lanes wide and holds one product
		for (genvar s = 0; s < VEC_W / (2 * LW); s++) begin : g_slot
			logic [LW-1:0] op_a;
			logic [LW-1:0] op_b;

			// Upper half of a slot is the even lane
			// Lower half is the odd lane
			assign op_a = odd ? a[2*LW*s +: LW] : a[2*LW*s + LW +: LW];
			assign op_b = odd ? b[2*LW*s +: LW] : b[2*LW*s + LW +: LW];

			// Unsigned product at full double width
			assign prod_w[g][2*LW*s +: 2*LW] = {{LW{1'b0}}, op_a} * {{LW{1'b0}}, op_b};
		end
	end

	// Pick the slot layout for the lane width
	always_comb begin
		case (width)
			LW_8:    prod = prod_w[0];
			LW_16:   prod = prod_w[1];
			LW_32:   prod = prod_w[2];
			// 64-bit lanes would need a 128-bit product
			default: prod = '0;
		endcase
	end

endmodule

// File: vec_lane_shift.sv
`timescale 1ns/1ps

module vec_lane_shift import vec_alu_pkg::*; (
	input  vec_t        a,
	input  lane_width_e width,
	input  vec_op_e     op,
	output vec_t        shifted
);

	// Results for lane widths 8, 16, 32 and 64
	logic [3:0][VEC_W-1:0] res_w;

	for (genvar g = 0; g < 4; g++) begin : g_width
		localparam int LW = 8 << g;
		// Shift count is log2 of the lane width
		localparam int SH = 3 + g;

		for (genvar l = 0; l < VEC_W / LW; l++) begin : g_lane
			logic [LW-1:0] lane_in;
			logic [LW-1:0] lane_out;

			assign lane_in = a[LW*l +: LW];

			always_comb begin
				case (op)
					OP_SLL:  lane_out = lane_in << SH;
					OP_SRL:  lane_out = lane_in >> SH;
					// Fill with the lane sign bit
					OP_SRA:  lane_out = $signed(lane_in) >>> SH;
					// Swap upper and lower halves
					OP_RTTH: lane_out = {lane_in[LW/2-1:0], lane_in[LW-1:LW/2]};
					default: lane_out = '0;
				endcase
			end

			assign res_w[g][LW*l +: LW] = lane_out;
		end
	end

	// Width select
	always_comb begin
		case (width)
			LW_8:    shifted = res_w[0];
			LW_16:   shifted = res_w[1];
			LW_32:   shifted = res_w[2];
			default: shifted = res_w[3];
		endcase
	end

endmodule

// File: vec_alu_core.sv
`timescale 1ns/1ps

module vec_alu_core import vec_alu_pkg::*; (
	input  vec_t      opa,
	input  vec_t      opb,
	input  vec_ctrl_t ctrl,
	output vec_t      result,
	output logic      unsupported
);

	vec_t addsub_res;
	vec_t mul_res;
	vec_t shift_res;
	logic is_mul;

	// Lane adder, subtract selected straight from the opcode
	vec_lane_addsub u_addsub (
		.a     (opa),
		.b     (opb),
		.width (ctrl.width),
		.sub   (ctrl.opcode == OP_SUB),
		.sum   (addsub_res)
	);

	// Even or odd lane multiply
	vec_lane_mul u_mul (
		.a     (opa),
		.b     (opb),
		.width (ctrl.width),
		.odd   (ctrl.opcode == OP_MULO),
		.prod  (mul_res)
	);

	// Shifts and rotate act on operand A only
	vec_lane_shift u_shift (
		.a       (opa),
		.width   (ctrl.width),
		.op      (ctrl.opcode),
		.shifted (shift_res)
	);

	assign is_mul = (ctrl.opcode == OP_MULE) || (ctrl.opcode == OP_MULO);

	// No double-width slot exists for 64-bit lanes
	assign unsupported = is_mul && (ctrl.width == LW_64);

	// Result select by opcode
	always_comb begin
		case (ctrl.opcode)
			OP_AND:  result = opa & opb;
			OP_OR:   result = opa | opb;
			OP_XOR:  result = opa ^ opb;
			OP_NOT:  result = ~opa;
			OP_MOV:  result = opa;
			OP_ADD,
			OP_SUB:  result = addsub_res;
			OP_MULE,
			OP_MULO: result = unsupported ? '0 : mul_res;
			OP_SLL,
			OP_SRL,
			OP_SRA,
			OP_RTTH: result = shift_res;
			// Unknown opcodes give zero
			default: result = '0;
		endcase
	end

endmodule

// File: vec_alu_top.sv
`timescale 1ns/1ps

module vec_alu_top import vec_alu_pkg::*; #(
	parameter int WB_ADR_W = vec_alu_pkg::WB_ADR_W
) (
	input  logic    clk,
	input  logic    arst_n,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	vec_t      opa;
	vec_t      opb;
	vec_ctrl_t ctrl;
	vec_t      result;
	logic      unsupported;

	// Host-facing register block
	wb_vec_regs #(
		.WB_ADR_W (WB_ADR_W)
	) u_regs (
		.clk         (clk),
		.arst_n      (arst_n),
		.wb_req      (wb_req),
		.wb_rsp      (wb_rsp),
		.opa         (opa),
		.opb         (opb),
		.ctrl        (ctrl),
		.result      (result),
		.unsupported (unsupported)
	);

	// Combinational ALU datapath
	vec_alu_core u_core (
		.opa         (opa),
		.opb         (opb),
		.ctrl        (ctrl),
		.result      (result),
		.unsupported (unsupported)
	);

endmodule

// File: tb_vec_alu_vectors.svh
// Each entry holds opa, opb, opcode, lane width, expected result and expected error flag
// Lane 0 is the most significant lane
localparam int NUM_VECTORS = 32;

localparam vec_entry_t VECTORS [NUM_VECTORS] = '{
	// Add wraps per lane, no carry into the neighbor
	'{64'h00FF_00FF_00FF_00FF, 64'h0101_0101_0101_0101, OP_ADD, LW_8, 64'h0100_0100_0100_0100, 1'b0},
	'{64'h0000_FFFF_1234_FFFF, 64'h0000_0001_0001_0001, OP_ADD, LW_16, 64'h0000_0000_1235_0000, 1'b0},
	'{64'h1234_5678_FFFF_FFFF, 64'h1111_1111_0000_0001, OP_ADD, LW_32, 64'h2345_6789_0000_0000, 1'b0},
	'{64'h0000_0000_FFFF_FFFF, 64'h0000_0000_0000_0001, OP_ADD, LW_64, 64'h0000_0001_0000_0000, 1'b0},
	// Zero minus one gives all ones in that lane only
	'{64'h0000_0000_0000_0000, 64'h0000_0000_0000_0001, OP_SUB, LW_8, 64'h0000_0000_0000_00FF, 1'b0},
	'{64'h0000_0000_0005_0000, 64'h0000_0000_0000_0001, OP_SUB, LW_16, 64'h0000_0000_0005_FFFF, 1'b0},
	'{64'h0000_0010_0000_0000, 64'h0000_0001_0000_0001, OP_SUB, LW_32, 64'h0000_000F_FFFF_FFFF, 1'b0},
	'{64'h0000_0001_0000_0000, 64'h0000_0000_0000_0001, OP_SUB, LW_64, 64'h0000_0000_FFFF_FFFF, 1'b0},
	// Even lanes 0 2 4 6, odd lanes 1 3 5 7
	'{64'hFF02_0304_0506_0708, 64'hFF10_0203_0405_0607, OP_MULE, LW_8, 64'hFE01_0006_0014_002A, 1'b0},
	'{64'hFF02_0304_0506_0708, 64'hFF10_0203_0405_0607, OP_MULO, LW_8, 64'h0020_000C_001E_0038, 1'b0},
	'{64'hFFFF_0002_1234_0003, 64'hFFFF_0005_0010_0007, OP_MULE, LW_16, 64'hFFFE_0001_0001_2340, 1'b0},
	'{64'hFFFF_0002_1234_0003, 64'hFFFF_0005_0010_0007, OP_MULO, LW_16, 64'h0000_000A_0000_0015, 1'b0},
	'{64'hFFFF_FFFF_0000_0003, 64'hFFFF_FFFF_0000_0005, OP_MULE, LW_32, 64'hFFFF_FFFE_0000_0001, 1'b0},
	'{64'hFFFF_FFFF_0000_0003, 64'hFFFF_FFFF_0000_0005, OP_MULO, LW_32, 64'h0000_0000_0000_000F, 1'b0},
	// No 64-bit multiply, next good op clears the flag
	'{64'h0000_0000_0000_0003, 64'h0000_0000_0000_0005, OP_MULE, LW_64, 64'h0000_0000_0000_0000, 1'b1},
	'{64'h8142_FF01_1020_0F80, 64'h0000_0000_0000_0000, OP_SLL, LW_8, 64'h0810_F808_8000_7800, 1'b0},
	'{64'h8142_FF01_1020_0F80, 64'h0000_0000_0000_0000, OP_SRL, LW_8, 64'h1008_1F00_0204_0110, 1'b0},
	'{64'h8142_FF01_1020_0F80, 64'h0000_0000_0000_0000, OP_SRA, LW_8, 64'hF008_FF00_0204_01F0, 1'b0},
	'{64'h8001_1234_FFFF_0F0F, 64'h0000_0000_0000_0000, OP_SLL, LW_16, 64'h0010_2340_FFF0_F0F0, 1'b0},
	'{64'h8001_1234_FFFF_0F0F, 64'h0000_0000_0000_0000, OP_SRL, LW_16, 64'h0800_0123_0FFF_00F0, 1'b0},
	'{64'h8001_1234_FFFF_0F0F, 64'h0000_0000_0000_0000, OP_SRA, LW_16, 64'hF800_0123_FFFF_00F0, 1'b0},
	'{64'h0800_0001_0000_0003, 64'h0000_0000_0000_0000, OP_SLL, LW_32, 64'h0000_0020_0000_0060, 1'b0},
	'{64'hFFFF_FFFF_0000_0100, 64'h0000_0000_0000_0000, OP_SRL, LW_32, 64'h07FF_FFFF_0000_0008, 1'b0},
	'{64'h8000_0000_0000_0400, 64'h0000_0000_0000_0000, OP_SRA, LW_32, 64'hFC00_0000_0000_0020, 1'b0},
	'{64'h0400_0000_0000_0003, 64'h0000_0000_0000_0000, OP_SLL, LW_64, 64'h0000_0000_0000_00C0, 1'b0},
	'{64'h8000_0000_0000_0040, 64'h0000_0000_0000_0000, OP_SRL, LW_64, 64'h0200_0000_0000_0001, 1'b0},
	'{64'h8000_0000_0000_0000, 64'h0000_0000_0000_0000, OP_SRA, LW_64, 64'hFE00_0000_0000_0000, 1'b0},
	'{64'h0000_0000_0000_0003, 64'h0000_0000_0000_0005, OP_MULO, LW_64, 64'h0000_0000_0000_0000, 1'b1},
	// Half swap within every lane
	'{64'h1234_5678_9ABC_DEF0, 64'h0000_0000_0000_0000, OP_RTTH, LW_8, 64'h2143_6587_A9CB_ED0F, 1'b0},
	'{64'h1234_5678_9ABC_DEF0, 64'h0000_0000_0000_0000, OP_RTTH, LW_16, 64'h3412_7856_BC9A_F0DE, 1'b0},
	'{64'h1234_5678_9ABC_DEF0, 64'h0000_0000_0000_0000, OP_RTTH, LW_32, 64'h5678_1234_DEF0_9ABC, 1'b0},
	'{64'h1234_5678_9ABC_DEF0, 64'h0000_0000_0000_0000, OP_RTTH, LW_64, 64'h9ABC_DEF0_1234_5678, 1'b0}
};

// File: tb_vec_alu.sv
`timescale 1ns/1ps

module tb_vec_alu import vec_alu_pkg::*; ();

	// One table row, expected values worked out from the lane rules
	typedef struct packed {
		vec_t        opa;
		vec_t        opb;
		vec_op_e     op;
		lane_width_e width;
		vec_t        exp_res;
		logic        exp_err;
	} vec_entry_t;

	`include "tb_vec_alu_vectors.svh"

	localparam int ACK_TIMEOUT = 20;
	localparam int NUM_RANDOM  = 20;
	localparam vec_op_e LOGIC_OPS [5] = '{OP_AND, OP_OR, OP_XOR, OP_NOT, OP_MOV};

	logic    clk;
	logic    arst_n;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	int num_checks;
	int num_mismatch;
	int num_timeout;
	bit bus_fail;

	vec_alu_top #(
		.WB_ADR_W (WB_ADR_W)
	) u_dut (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	// 10 ns clock
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Bitwise reference for the logic opcodes
	function automatic vec_t logic_expect(input vec_op_e op, input vec_t a, input vec_t b);
		case (op)
			OP_AND:  return a & b;
			OP_OR:   return a | b;
			OP_XOR:  return a ^ b;
			OP_NOT:  return ~a;
			default: return a;
		endcase
	endfunction

	task automatic compare_value(input string name, input vec_t got, input vec_t exp);
		num_checks++;
		assert (got === exp) else begin
			$display("mismatch at %0t ns: %s expected %h, got %h", $time, name, exp, got);
			num_mismatch++;
		end
	endtask

	// Single classic write, stb dropped on the falling edge that sees ack
	task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input vec_t dat);
		bit got_ack;
		int n;
		got_ack = 1'b0;
		if (bus_fail) return;
		@(negedge clk);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b1;
		wb_req.adr = adr;
		wb_req.dat = dat;
		for (n = 0; n < ACK_TIMEOUT && !got_ack; n++) begin
			@(negedge clk);
			got_ack = wb_rsp.ack;
		end
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		wb_req.we  = 1'b0;
		assert (got_ack) else begin
			$display("no ack from slave on write to address %0d at %0t ns", adr, $time);
			num_timeout++;
			bus_fail = 1'b1;
		end
	endtask

	// Single classic read, data taken while ack is high
	task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output vec_t dat);
		bit got_ack;
		int n;
		got_ack = 1'b0;
		dat     = '0;
		if (bus_fail) return;
		@(negedge clk);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = 1'b0;
		wb_req.adr = adr;
		for (n = 0; n < ACK_TIMEOUT && !got_ack; n++) begin
			@(negedge clk);
			got_ack = wb_rsp.ack;
			dat     = wb_rsp.dat;
		end
		wb_req.cyc = 1'b0;
		wb_req.stb = 1'b0;
		assert (got_ack) else begin
			$display("no ack from slave on read of address %0d at %0t ns", adr, $time);
			num_timeout++;
			bus_fail = 1'b1;
		end
	endtask

	// Load both operands, start the op, then read result and status
	task automatic run_op(input string tag, input vec_t a, input vec_t b, input vec_op_e op,
		input lane_width_e w, input vec_t exp_res, input logic exp_err);
		vec_t res;
		vec_t stat;
		wb_write(REG_OPA, a);
		wb_write(REG_OPB, b);
		wb_write(REG_CTRL, vec_t'({op, w}));
		wb_read(REG_CTRL, res);
		wb_read(REG_STAT, stat);
		if (!bus_fail) begin
			compare_value($sformatf("%s result (%s)", tag, op.name()), res, exp_res);
			compare_value($sformatf("%s error flag", tag), stat, vec_t'(exp_err));
		end
	endtask

	initial begin
		vec_t        a;
		vec_t        b;
		vec_t        rd;
		vec_op_e     op;
		lane_width_e w;
		int          i;
		void'($urandom(32'h5f6e85f0));
		num_checks   = 0;
		num_mismatch = 0;
		num_timeout  = 0;
		bus_fail     = 1'b0;
		arst_n       = 1'b0;
		wb_req       = '0;

		// Reset held for 4 cycles
		repeat (4) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Idle bus and cleared registers after reset
		compare_value("wb_rsp.ack after reset", vec_t'(wb_rsp.ack), '0);
		for (i = 0; i < 4; i++) begin
			wb_read(WB_ADR_W'(i), rd);
			if (!bus_fail) begin
				compare_value($sformatf("register %0d after reset", i), rd, '0);
			end
		end

		// Directed table, add, sub, multiply, shifts and rotate
		for (i = 0; i < NUM_VECTORS; i++) begin
			run_op($sformatf("entry %0d", i), VECTORS[i].opa, VECTORS[i].opb,
				VECTORS[i].op, VECTORS[i].width, VECTORS[i].exp_res, VECTORS[i].exp_err);
		end

		// Logic ops on random operands, width has no effect
		for (i = 0; i < NUM_RANDOM; i++) begin
			a  = {$urandom, $urandom};
			b  = {$urandom, $urandom};
			op = LOGIC_OPS[i % 5];
			w  = lane_width_e'(2'($urandom));
			run_op($sformatf("random %0d", i), a, b, op, w, logic_expect(op, a, b), 1'b0);
		end

		$display("summary: %0d checks, %0d mismatches, %0d bus timeouts",
			num_checks, num_mismatch, num_timeout);
		if (num_mismatch == 0 && num_timeout == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: vec_alu_top.f
+incdir+.
vec_alu_pkg.sv
wb_vec_regs.sv
vec_lane_addsub.sv
vec_lane_mul.sv
vec_lane_shift.sv
vec_alu_core.sv
vec_alu_top.sv
tb_vec_alu.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tb_vec_alu
FILELIST  := vec_alu_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "pass line not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
